// File: dv/approx_mul_tests.txt
// Columns, all hex: opcode (0 exact, 1 approx), a, b, expected product,
// downstream credit delay in cycles
0 00 00 0000 01
0 FF FF FE01 00
0 05 07 0023 02
0 0F 0F 00E1 01
0 0C 09 006C 00
0 12 34 03A8 03
1 FF FF FDE1 00
1 05 07 0023 01
1 12 34 03A8 00
1 A5 3C 267C 1E
0 A5 3C 26AC 14
1 3B 5D 15EF 19
0 3B 5D 156F 00
1 FF 0F 0EF1 02
1 C8 64 4E20 00
0 C8 64 4E20 01
1 77 99 46FF 28
0 77 99 471F 00
1 E6 B9 A636 03
1 FF F8 F6F8 01
0 80 02 0100 00
0 FF F8 F708 02

// File: project.f
rtl/approx_mul_pkg.sv
rtl/operand_buffer.sv
rtl/rec_mul4.sv
rtl/lower_or_adder.sv
rtl/approx_mul8.sv
rtl/mul_stage.sv
rtl/result_sender.sv
rtl/approx_mul_top.sv
dv/tb_approx_mul.sv

// File: dv/tb_approx_mul.sv
`timescale 1ns/1ns

module tb_approx_mul;

    localparam int IN_DEPTH    = 4;
    localparam int OUT_CREDITS = 2;
    localparam int APPROX_BITS = 4;
    localparam int MAX_VEC     = 64;
    localparam int WAIT_LIMIT  = 2000;

    logic                    clk;
    logic                    reset;
    logic                    in_valid;
    approx_mul_pkg::mul_op_e in_op;
    logic [7:0]              in_a;
    logic [7:0]              in_b;
    logic                    out_credit;
    logic                    in_credit;
    logic                    out_valid;
    logic [15:0]             out_p;

    // Each vector takes five words in order op, a, b, expected product and credit delay
    logic [15:0] vec_mem [0:5*MAX_VEC-1];
    logic [15:0] exp_q [$];
    int          delay_q [$];
    int          due_q [$];
    logic [15:0] lfsr;

    int cycle;
    int num_vec;
    int up_credits;
    int sent;
    int received;
    int credit_pulses;
    int outstanding;
    int check_errors;
    int protocol_errors;
    int timeouts;
    bit aborted;

    approx_mul_top #(
        .IN_DEPTH    (IN_DEPTH),
        .OUT_CREDITS (OUT_CREDITS),
        .APPROX_BITS (APPROX_BITS)
    ) u_approx_mul_top (
        .clk        (clk),
        .reset      (reset),
        .in_valid   (in_valid),
        .in_op      (in_op),
        .in_a       (in_a),
        .in_b       (in_b),
        .out_credit (out_credit),
        .in_credit  (in_credit),
        .out_valid  (out_valid),
        .out_p      (out_p)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    task automatic check_value(input string name, input logic [15:0] got,
                               input logic [15:0] exp);
        if (got !== exp) begin
            check_errors++;
            $display("CHECK FAILED at %0t ns: %s got %h expected %h", $time, name, got, exp);
        end
    endtask

    function automatic logic take_bit();
        logic b;
        b = lfsr[0];
        lfsr = lfsr[0] ? ((lfsr >> 1) ^ 16'hB400) : (lfsr >> 1);
        return b;
    endfunction

    // One in four vectors waits one or two extra cycles
    function automatic int random_gap();
        int v;
        v = 0;
        repeat (3) begin
            v = (v << 1) | int'(take_bit());
        end
        return (v >= 6) ? v - 5 : 0;
    endfunction

    // Upstream and downstream bookkeeping sampled on the rising edge
    always @(posedge clk) begin
        cycle++;
        if (!reset) begin
            if (in_credit) begin
                credit_pulses++;
                up_credits++;
            end
            if (out_credit) begin
                outstanding--;
            end
            if (out_valid) begin
                outstanding++;
                if (exp_q.size() == 0) begin
                    protocol_errors++;
                    $display("Result %h at %0t ns arrived with no input pending", out_p, $time);
                end else begin
                    check_value("out_p", out_p, exp_q.pop_front());
                    due_q.push_back(cycle + delay_q.pop_front());
                    received++;
                end
            end
            if (outstanding > OUT_CREDITS || up_credits > IN_DEPTH) begin
                protocol_errors++;
                $display("Credit limit broken at %0t ns: %0d results held, %0d input credits",
                         $time, outstanding, up_credits);
            end
        end
    end

    // Downstream returns one credit per cycle once its delay has run out
    initial begin
        out_credit = 1'b0;
        forever begin
            @(negedge clk);
            out_credit = 1'b0;
            if (due_q.size() > 0 && due_q[0] <= cycle) begin
                void'(due_q.pop_front());
                out_credit = 1'b1;
            end
        end
    end

    task automatic send_all();
        int wait_cnt;
        int gap;
        for (int i = 0; i < num_vec && !aborted; i++) begin
            gap = random_gap();
            repeat (gap) @(negedge clk);
            wait_cnt = 0;
            while (up_credits == 0 && wait_cnt < WAIT_LIMIT) begin
                @(negedge clk);
                wait_cnt++;
            end
            if (up_credits == 0) begin
                timeouts++;
                aborted = 1'b1;
                $display("Timeout at %0t ns: no input credit came back for vector %0d", $time, i);
            end else begin
                in_valid = 1'b1;
                in_op    = approx_mul_pkg::mul_op_e'(vec_mem[5*i][0]);
                in_a     = vec_mem[5*i+1][7:0];
                in_b     = vec_mem[5*i+2][7:0];
                exp_q.push_back(vec_mem[5*i+3]);
                delay_q.push_back(int'(vec_mem[5*i+4]));
                up_credits--;
                sent++;
                @(negedge clk);
                in_valid = 1'b0;
            end
        end
    endtask

    task automatic wait_drain();
        int wait_cnt;
        wait_cnt = 0;
        while (!(received == sent && due_q.size() == 0 && outstanding == 0) &&
               wait_cnt < WAIT_LIMIT) begin
            @(negedge clk);
            wait_cnt++;
        end
        if (wait_cnt >= WAIT_LIMIT) begin
            timeouts++;
            $display("Timeout at %0t ns: %0d of %0d results received, pipeline did not drain",
                     $time, received, sent);
        end
    endtask

    initial begin
        reset    = 1'b1;
        in_valid = 1'b0;
        in_op    = approx_mul_pkg::OP_EXACT;
        in_a     = '0;
        in_b     = '0;
        lfsr     = 16'd19;
        up_credits = IN_DEPTH;
        $readmemh("dv/approx_mul_tests.txt", vec_mem);
        while (num_vec < MAX_VEC && !$isunknown(vec_mem[5*num_vec])) begin
            num_vec++;
        end
        if (num_vec == 0) begin
            protocol_errors++;
            $display("No vectors could be read from dv/approx_mul_tests.txt");
        end
        repeat (4) @(posedge clk);
        @(negedge clk);
        reset = 1'b0;
        // Nothing may come out while idle after reset
        repeat (3) begin
            @(posedge clk);
            check_value("out_valid", out_valid, 1'b0);
            check_value("in_credit", in_credit, 1'b0);
        end
        @(negedge clk);
        send_all();
        if (!aborted) begin
            wait_drain();
        end
        check_value("in_credit pulses", credit_pulses, sent);
        check_value("results received", received, num_vec);
        $display("Errors: %0d check, %0d protocol, %0d timeout (%0d vectors)",
                 check_errors, protocol_errors, timeouts, num_vec);
        if (check_errors + protocol_errors + timeouts == 0) begin
            $display("*** TEST PASSED ***");
        end else begin
            $display("*** TEST FAILED ***");
        end
        $finish;
    end

endmodule

// File: rtl/approx_mul_top.sv
`timescale 1ns/1ns

module approx_mul_top #(
    parameter int IN_DEPTH    = 4,
    parameter int OUT_CREDITS = 2,
    parameter int APPROX_BITS = 4
) (
    input  logic                                clk,
    input  logic                                reset,
    input  logic                                in_valid,
    input  approx_mul_pkg::mul_op_e             in_op,
    input  logic [approx_mul_pkg::OPND_W-1:0]   in_a,
    input  logic [approx_mul_pkg::OPND_W-1:0]   in_b,
    input  logic                                out_credit,
    output logic                                in_credit,
    output logic                                out_valid,
    output logic [approx_mul_pkg::PROD_W-1:0]   out_p
);

    logic                                 buf_valid;
    approx_mul_pkg::mul_op_e              buf_op;
    logic [approx_mul_pkg::OPND_W-1:0]    buf_a;
    logic [approx_mul_pkg::OPND_W-1:0]    buf_b;
    logic                                 stage_ready;
    logic                                 prod_valid;
    logic [approx_mul_pkg::PROD_W-1:0]    prod_p;
    logic                                 send_ready;

    operand_buffer #(.IN_DEPTH(IN_DEPTH)) u_operand_buffer (
        .clk         (clk),
        .reset       (reset),
        .in_valid    (in_valid),
        .in_op       (in_op),
        .in_a        (in_a),
        .in_b        (in_b),
        .stage_ready (stage_ready),
        .in_credit   (in_credit),
        .buf_valid   (buf_valid),
        .buf_op      (buf_op),
        .buf_a       (buf_a),
        .buf_b       (buf_b)
    );

    mul_stage #(.APPROX_BITS(APPROX_BITS)) u_mul_stage (
        .clk         (clk),
        .reset       (reset),
        .buf_valid   (buf_valid),
        .buf_op      (buf_op),
        .buf_a       (buf_a),
        .buf_b       (buf_b),
        .send_ready  (send_ready),
        .stage_ready (stage_ready),
        .prod_valid  (prod_valid),
        .prod_p      (prod_p)
    );

    result_sender #(.OUT_CREDITS(OUT_CREDITS)) u_result_sender (
        .clk        (clk),
        .reset      (reset),
        .prod_valid (prod_valid),
        .prod_p     (prod_p),
        .out_credit (out_credit),
        .send_ready (send_ready),
        .out_valid  (out_valid),
        .out_p      (out_p)
    );

endmodule

// File: rtl/result_sender.sv
`timescale 1ns/1ns

module result_sender #(
    parameter int OUT_CREDITS = 2
) (
    input  logic                                clk,
    input  logic                                reset,
    input  logic                                prod_valid,
    input  logic [approx_mul_pkg::PROD_W-1:0]   prod_p,
    input  logic                                out_credit,
    output logic                                send_ready,
    output logic                                out_valid,
    output logic [approx_mul_pkg::PROD_W-1:0]   out_p
);

    localparam int CNT_W = $clog2(OUT_CREDITS + 1);

    logic                                 held_valid;
    logic [approx_mul_pkg::PROD_W-1:0]    held_p;
    logic [CNT_W-1:0]                     credit_cnt;
    logic                                 take;

    assign send_ready = !held_valid;
    assign take       = prod_valid && send_ready;

    // Send as soon as a credit is on hand
    assign out_valid = held_valid && (credit_cnt != '0);
    assign out_p     = held_p;

    always_ff @(posedge clk) begin
        if (reset) begin
            held_valid <= 1'b0;
            credit_cnt <= CNT_W'(OUT_CREDITS);
        end else begin
            if (take) begin
                held_valid <= 1'b1;
            end else if (out_valid) begin
                held_valid <= 1'b0;
            end
            // Downstream only returns credits it was given
            credit_cnt <= credit_cnt - CNT_W'(out_valid) + CNT_W'(out_credit);
        end
    end

    always_ff @(posedge clk) begin
        if (take) begin
            held_p <= prod_p;
        end
    end

endmodule

// File: rtl/mul_stage.sv
`timescale 1ns/1ns

module mul_stage #(
    parameter int APPROX_BITS = 4
) (
    input  logic                                clk,
    input  logic                                reset,
    input  logic                                buf_valid,
    input  approx_mul_pkg::mul_op_e             buf_op,
    input  logic [approx_mul_pkg::OPND_W-1:0]   buf_a,
    input  logic [approx_mul_pkg::OPND_W-1:0]   buf_b,
    input  logic                                send_ready,
    output logic                                stage_ready,
    output logic                                prod_valid,
    output logic [approx_mul_pkg::PROD_W-1:0]   prod_p
);

    logic                                 s1_valid;
    approx_mul_pkg::mul_op_e              s1_op;
    logic [approx_mul_pkg::OPND_W-1:0]    s1_a;
    logic [approx_mul_pkg::OPND_W-1:0]    s1_b;
    logic [approx_mul_pkg::PROD_W-1:0]    mul_p;
    logic                                 stall;
    logic                                 s1_load;

    assign stall       = prod_valid && !send_ready;
    // Stage 1 may still fill while stage 2 waits
    assign stage_ready = !(s1_valid && stall);
    assign s1_load     = !s1_valid || !stall;

    approx_mul8 #(.APPROX_BITS(APPROX_BITS)) u_mul (
        .op (s1_op),
        .a  (s1_a),
        .b  (s1_b),
        .p  (mul_p)
    );

    always_ff @(posedge clk) begin
        if (reset) begin
            s1_valid   <= 1'b0;
            prod_valid <= 1'b0;
        end else begin
            if (s1_load) begin
                s1_valid <= buf_valid;
            end
            if (!stall) begin
                prod_valid <= s1_valid;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (s1_load && buf_valid) begin
            s1_op <= buf_op;
            s1_a  <= buf_a;
            s1_b  <= buf_b;
        end
        if (!stall && s1_valid) begin
            prod_p <= mul_p;
        end
    end

endmodule

// File: rtl/approx_mul8.sv
`timescale 1ns/1ns

module approx_mul8 #(
    parameter int APPROX_BITS = 4
) (
    input  approx_mul_pkg::mul_op_e             op,
    input  logic [approx_mul_pkg::OPND_W-1:0]   a,
    input  logic [approx_mul_pkg::OPND_W-1:0]   b,
    output logic [approx_mul_pkg::PROD_W-1:0]   p
);

    logic [7:0]  pp_hh;
    logic [7:0]  pp_hl;
    logic [7:0]  pp_lh;
    logic [7:0]  pp_ll;
    logic [8:0]  mid_sum;
    logic [11:0] upper_op;
    logic [11:0] upper_sum;
    logic        use_approx;

    rec_mul4 #(.LO_SPLIT(2)) u_mul_hh (
        .a (a[7:4]),
        .b (b[7:4]),
        .p (pp_hh)
    );

    rec_mul4 #(.LO_SPLIT(2)) u_mul_hl (
        .a (a[7:4]),
        .b (b[3:0]),
        .p (pp_hl)
    );

    rec_mul4 #(.LO_SPLIT(2)) u_mul_lh (
        .a (a[3:0]),
        .b (b[7:4]),
        .p (pp_lh)
    );

    // Uneven 1/3 split on the low-by-low block
    rec_mul4 #(.LO_SPLIT(3)) u_mul_ll (
        .a (a[3:0]),
        .b (b[3:0]),
        .p (pp_ll)
    );

    assign mid_sum    = pp_hl + pp_lh;
    assign upper_op   = {pp_hh, pp_ll[7:4]};
    assign use_approx = (op == approx_mul_pkg::OP_APPROX);

    lower_or_adder #(.APPROX_BITS(APPROX_BITS)) u_final_add (
        .approx (use_approx),
        .x      (upper_op),
        .y      (mid_sum),
        .s      (upper_sum)
    );

    assign p = {upper_sum, pp_ll[3:0]};

endmodule

// File: rtl/lower_or_adder.sv
`timescale 1ns/1ns

module lower_or_adder #(
    parameter int APPROX_BITS = 4
) (
    input  logic        approx,
    input  logic [11:0] x,
    input  logic [8:0]  y,
    output logic [11:0] s
);

    // Bits below APPROX_BITS form the OR part
    localparam logic [11:0] LO_MASK  = (12'd1 << APPROX_BITS) - 12'd1;
    localparam logic [11:0] TOP_MASK = LO_MASK ^ (LO_MASK >> 1);

    logic [11:0] y_ext;
    logic [11:0] exact_sum;
    logic [11:0] lo_or;
    logic        lo_carry;
    logic [11:0] hi_sum;

    assign y_ext     = {3'b000, y};
    assign exact_sum = x + y_ext;

    assign lo_or    = (x | y_ext) & LO_MASK;
    assign lo_carry = |(x & y_ext & TOP_MASK);

    // Upper part stays exact, carry enters at bit APPROX_BITS
    assign hi_sum = (x & ~LO_MASK) + (y_ext & ~LO_MASK) + ({11'd0, lo_carry} << APPROX_BITS);

    assign s = approx ? (hi_sum | lo_or) : exact_sum;

endmodule

// File: rtl/rec_mul4.sv
`timescale 1ns/1ns

module rec_mul4 #(
    parameter int LO_SPLIT = 2
) (
    input  logic [3:0] a,
    input  logic [3:0] b,
    output logic [7:0] p
);

    localparam int HI_W = 4 - LO_SPLIT;
    localparam int UP_W = 8 - LO_SPLIT;

    logic [HI_W-1:0]       a_h;
    logic [HI_W-1:0]       b_h;
    logic [LO_SPLIT-1:0]   a_l;
    logic [LO_SPLIT-1:0]   b_l;

    logic [2*HI_W-1:0]     pp_hh;
    logic [3:0]            pp_hl;
    logic [3:0]            pp_lh;
    logic [2*LO_SPLIT-1:0] pp_ll;

    logic [4:0]            mid;
    logic [UP_W-1:0]       upper_op;
    logic [UP_W-1:0]       upper_sum;

    assign a_h = a[3:LO_SPLIT];
    assign b_h = b[3:LO_SPLIT];
    assign a_l = a[LO_SPLIT-1:0];
    assign b_l = b[LO_SPLIT-1:0];

    // Small exact products on the split pieces
    assign pp_hh = a_h * b_h;
    assign pp_hl = a_h * b_l;
    assign pp_lh = a_l * b_h;
    assign pp_ll = a_l * b_l;

    assign mid = pp_hl + pp_lh;

    // High product on top of the upper half of the low product
    assign upper_op  = {pp_hh, pp_ll[2*LO_SPLIT-1:LO_SPLIT]};
    assign upper_sum = upper_op + mid;

    assign p = {upper_sum, pp_ll[LO_SPLIT-1:0]};

endmodule

// File: rtl/operand_buffer.sv
`timescale 1ns/1ns

module operand_buffer #(
    parameter int IN_DEPTH = 4
) (
    input  logic                                clk,
    input  logic                                reset,
    input  logic                                in_valid,
    input  approx_mul_pkg::mul_op_e             in_op,
    input  logic [approx_mul_pkg::OPND_W-1:0]   in_a,
    input  logic [approx_mul_pkg::OPND_W-1:0]   in_b,
    input  logic                                stage_ready,
    output logic                                in_credit,
    output logic                                buf_valid,
    output approx_mul_pkg::mul_op_e             buf_op,
    output logic [approx_mul_pkg::OPND_W-1:0]   buf_a,
    output logic [approx_mul_pkg::OPND_W-1:0]   buf_b
);

    localparam int PTR_W = (IN_DEPTH > 1) ? $clog2(IN_DEPTH) : 1;
    localparam int CNT_W = $clog2(IN_DEPTH + 1);

    approx_mul_pkg::mul_op_e              mem_op [IN_DEPTH];
    logic [approx_mul_pkg::OPND_W-1:0]    mem_a  [IN_DEPTH];
    logic [approx_mul_pkg::OPND_W-1:0]    mem_b  [IN_DEPTH];

    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [CNT_W-1:0] count;
    logic             pop;

    assign buf_valid = (count != '0);
    assign pop       = buf_valid && stage_ready;

    assign buf_op = mem_op[rd_ptr];
    assign buf_a  = mem_a[rd_ptr];
    assign buf_b  = mem_b[rd_ptr];

    // Upstream never writes without a credit, so no full check here
    always_ff @(posedge clk) begin
        if (in_valid) begin
            mem_op[wr_ptr] <= in_op;
            mem_a[wr_ptr]  <= in_a;
            mem_b[wr_ptr]  <= in_b;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            wr_ptr    <= '0;
            rd_ptr    <= '0;
            count     <= '0;
            in_credit <= 1'b0;
        end else begin
            if (in_valid) begin
                wr_ptr <= (wr_ptr == PTR_W'(IN_DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= (rd_ptr == PTR_W'(IN_DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            end
            count     <= count + CNT_W'(in_valid) - CNT_W'(pop);
            // One credit back per freed slot
            in_credit <= pop;
        end
    end

endmodule

// File: rtl/approx_mul_pkg.sv
package approx_mul_pkg;

    // Operand and product widths of the streaming multiplier
    localparam int OPND_W = 8;
    localparam int PROD_W = 16;

    // Per-pair opcode, carried alongside the operands
    typedef enum logic {
        OP_EXACT  = 1'b0,
        OP_APPROX = 1'b1
    } mul_op_e;

endpackage
